// File: flist.f
design/support_pkg.sv
design/ring_node.sv
design/support_regs.sv
design/event_interrupt.sv
design/support_top.sv
verification/support_assertions.sv
verification/tb_support.sv

// File: Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0
TOP        := tb_support
FLIST      := flist.f
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_support.sv
// Assumes the window 0x40 to 0x47 and a ring word on every cycle so the model queue stays aligned
`timescale 1ns/1ps

module tb_support import support_pkg::*; ();

  localparam logic [15:0] TB_BLKID = 16'hb1d7;
  localparam logic [RING_ADDR_W-1:0] WIN_START = 16'h0040;
  localparam logic [RING_ADDR_W-1:0] WIN_END = 16'h0047;
  localparam logic [N_INT_SRC-1:0] SRC_MASK = 16'h3fff; // Two reserved sources never set status
  localparam int N1 = 200;
  localparam int N2 = 60;
  localparam int N4 = 20;
  localparam int N5 = 80;
  localparam int TEST_CYCLES = N1 + 2 * N2 + 20 + 6 * N4 + 8 * N5 + 40;
  localparam int MAX_CYCLES = 2 * TEST_CYCLES;
  localparam int CMP_W = $bits(rbus_t);

  typedef struct packed {
    rbus_t                  ring;
    im_flags_t              cons;
    logic [RING_DATA_W-1:0] ctl;
  } exp_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  rbus_t                  i_ring;
  im_flags_t              i_im_avail;
  int_src_t               i_int_src;
  rbus_t                  o_ring;
  im_flags_t              o_im_consumed;
  logic [RING_DATA_W-1:0] o_ctl;
  logic                   o_int;

  integer                 seed = 32'h81b7f48c;
  int                     cycles = 0;
  int                     checks = 0;
  int                     errors = 0;
  int                     tests = 0;
  int                     test_start_err = 0;
  exp_t                   exp_q[$];
  logic [RING_DATA_W-1:0] ctl_m;
  logic [N_INT_SRC-1:0]   status_m;
  logic [N_INT_SRC-1:0]   enable_m;
  im_flags_t              avail_m;

  support_top #(
    .BLKID (TB_BLKID)
  ) dut_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_ring           (i_ring),
    .i_cfg_start_addr (WIN_START),
    .i_cfg_end_addr   (WIN_END),
    .i_im_avail       (i_im_avail),
    .i_int_src        (i_int_src),
    .o_ring           (o_ring),
    .o_im_consumed    (o_im_consumed),
    .o_ctl            (o_ctl),
    .o_int            (o_int)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  task automatic compare_value(input string name, input logic [CMP_W-1:0] got,
                               input logic [CMP_W-1:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
    end
  endtask

  // Builds the expected output word and applies register side effects in issue order
  task automatic model_word(input rbus_t w, output exp_t e);
    logic [LOCL_ADDR_W-1:0] idx;
    logic [RING_DATA_W-1:0] rdata;
    logic                   bad;
    e.ring = w;
    e.cons = '0;
    if ((w.rd_strb || w.wr_strb) && !w.ack && !w.err_ack &&
        (w.addr >= WIN_START) && (w.addr <= WIN_END)) begin
      idx = LOCL_ADDR_W'(w.addr - WIN_START);
      rdata = '0;
      bad = 1'b0;
      case (idx)
        REG_BLKID: begin
          bad = w.wr_strb;
          rdata = {16'h0000, TB_BLKID};
        end
        REG_CTL: rdata = ctl_m;
        REG_IM_AVAIL: begin
          bad = w.wr_strb;
          rdata = {26'h0, avail_m};
        end
        REG_IM_CONSUMED: bad = !w.wr_strb;
        REG_INT_STATUS: rdata = {16'h0000, status_m};
        REG_INT_ENABLE: rdata = {16'h0000, enable_m};
        default: bad = 1'b1;
      endcase
      e.ring.ack = !bad;
      e.ring.err_ack = bad;
      if (!w.wr_strb) begin
        e.ring.rd_data = rdata;
      end
      if (w.wr_strb && !bad) begin
        case (idx)
          REG_CTL: ctl_m = w.wr_data;
          REG_IM_CONSUMED: e.cons = im_flags_t'(w.wr_data[5:0]);
          REG_INT_STATUS: status_m = status_m & ~w.wr_data[15:0];
          REG_INT_ENABLE: enable_m = w.wr_data[15:0];
          default: ;
        endcase
      end
    end
    e.ctl = ctl_m;
  endtask

  task automatic drive_cycle(input rbus_t w, input logic [N_INT_SRC-1:0] src);
    exp_t e;
    @(posedge clk);
    i_ring <= w;
    i_int_src <= int_src_t'(src);
    i_im_avail <= avail_m;
    status_m = status_m | (src & SRC_MASK); // A read issued now already sees these bits
    model_word(w, e);
    exp_q.push_back(e);
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle('0, '0);
  endtask

  function automatic rbus_t make_access(input logic [RING_ADDR_W-1:0] addr, input logic wr,
                                        input logic [RING_DATA_W-1:0] data);
    rbus_t w;
    w = '0;
    w.addr = addr;
    w.wr_strb = wr;
    w.rd_strb = !wr;
    w.wr_data = data;
    w.rd_data = rand32();
    return w;
  endfunction

  task automatic finish_test(input string name);
    idle(3);
    tests++;
    $display("Test %0d %s finished with %0d errors", tests, name, errors - test_start_err);
    test_start_err = errors;
  endtask

  // Two words are always in flight on the output side of the model
  always @(negedge clk) begin : check_outputs
    exp_t e;
    if (exp_q.size() > 2) begin
      e = exp_q.pop_front();
      compare_value("o_ring", o_ring, e.ring);
      compare_value("o_im_consumed", CMP_W'(o_im_consumed), CMP_W'(e.cons));
      compare_value("o_ctl", CMP_W'(o_ctl), CMP_W'(e.ctl));
    end
  end

  initial begin
    rbus_t       w;
    logic [31:0] r;
    exp_t        blank;
    rst_n = 1'b0;
    i_ring = '0;
    i_im_avail = '0;
    i_int_src = '0;
    ctl_m = '0;
    status_m = '0;
    enable_m = '0;
    avail_m = '0;
    blank = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    exp_q.push_back(blank);
    exp_q.push_back(blank);

    for (int i = 0; i < N1; i++) begin
      r = rand32();
      w.addr = r[15:0];
      w.wr_strb = r[16];
      w.rd_strb = r[17];
      w.ack = r[18];
      w.err_ack = r[19];
      w.wr_data = rand32();
      w.rd_data = rand32();
      if (r[20]) begin
        w.addr = WIN_START + {13'h0, r[23:21]};
        w.ack = w.ack | !w.err_ack; // Already answered upstream
      end else if ((w.addr >= WIN_START) && (w.addr <= WIN_END)) begin
        w.addr = w.addr ^ 16'h8000;
      end
      drive_cycle(w, '0);
    end
    finish_test("ring pass-through");

    for (int i = 0; i < N2; i++) begin
      drive_cycle(make_access(WIN_START + 16'd1, 1'b1, rand32()), '0);
      drive_cycle(make_access(WIN_START + 16'd1, 1'b0, rand32()), '0);
    end
    finish_test("control write and read");

    drive_cycle(make_access(WIN_START, 1'b0, rand32()), '0);
    drive_cycle(make_access(WIN_START, 1'b1, rand32()), '0);
    drive_cycle(make_access(WIN_START + 16'd2, 1'b1, rand32()), '0);
    drive_cycle(make_access(WIN_START + 16'd3, 1'b0, rand32()), '0);
    drive_cycle(make_access(WIN_START + 16'd6, 1'b0, rand32()), '0);
    drive_cycle(make_access(WIN_START + 16'd6, 1'b1, rand32()), '0);
    drive_cycle(make_access(WIN_START + 16'd7, 1'b0, rand32()), '0);
    drive_cycle(make_access(WIN_START + 16'd7, 1'b1, rand32()), '0);
    drive_cycle(make_access(WIN_START + 16'd1, 1'b0, rand32()), '0);
    finish_test("ID and access errors");

    for (int i = 0; i < N4; i++) begin
      r = rand32();
      avail_m = im_flags_t'(r[5:0]);
      idle(1);
      drive_cycle(make_access(WIN_START + 16'd2, 1'b0, rand32()), '0);
      drive_cycle(make_access(WIN_START + 16'd3, 1'b1, rand32()), '0);
      idle(1); // Keeps consumed writes one cycle apart
    end
    finish_test("available flags and consumed pulses");

    for (int i = 0; i < N5; i++) begin
      r = rand32();
      case (r[1:0])
        2'd0: begin
          drive_cycle('0, 16'(r[31:16] & (rand32() >> 16)));
          drive_cycle(make_access(WIN_START + 16'd4, 1'b0, rand32()), '0);
        end
        2'd1: drive_cycle(make_access(WIN_START + 16'd5, 1'b1, rand32()), '0);
        2'd2: drive_cycle(make_access(WIN_START + 16'd4, 1'b1, rand32()), '0);
        default: begin
          drive_cycle(make_access(WIN_START + 16'd4, 1'b0, rand32()), '0);
          drive_cycle(make_access(WIN_START + 16'd5, 1'b0, rand32()), '0);
        end
      endcase
      idle(3);
      @(negedge clk);
      compare_value("o_int", CMP_W'(o_int), CMP_W'(|(status_m & enable_m)));
    end
    finish_test("interrupt status and enable");

    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verification/support_assertions.sv
// Bound to the top level and watches ring latency, single-cycle consumed pulses and interrupt reset
`timescale 1ns/1ps

module support_assertions import support_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input rbus_t     i_ring,
  input rbus_t     o_ring,
  input im_flags_t o_im_consumed,
  input logic      o_int
);

  logic [$bits(im_flags_t)-1:0] cons_bits;

  assign cons_bits = o_im_consumed;

  // A word that leaves with no ack added comes out exactly as it went in
  property p_ring_latency;
    @(posedge clk) disable iff (!rst_n)
      ((o_ring.ack == $past(i_ring.ack, 2)) && (o_ring.err_ack == $past(i_ring.err_ack, 2)))
      |-> (o_ring == $past(i_ring, 2));
  endproperty

  a_ring_latency: assert property (p_ring_latency)
    else $error("ring word changed on its way through the node");

  a_consumed_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    (cons_bits & $past(cons_bits)) == '0)
    else $error("consumed pulse held high for two cycles");

  a_int_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !o_int)
    else $error("interrupt high in the first cycle after reset");

endmodule

bind support_top support_assertions u_assert (
  .clk           (clk),
  .rst_n         (rst_n),
  .i_ring        (i_ring),
  .o_ring        (o_ring),
  .o_im_consumed (o_im_consumed),
  .o_int         (o_int)
);

// File: design/support_top.sv
// Window bounds are inclusive word addresses and every ring word leaves the node two cycles later
`timescale 1ns/1ps

module support_top import support_pkg::*; #(
  parameter logic [15:0] BLKID = DEFAULT_BLKID
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rbus_t                  i_ring,
  input  logic [RING_ADDR_W-1:0] i_cfg_start_addr,
  input  logic [RING_ADDR_W-1:0] i_cfg_end_addr,
  input  im_flags_t              i_im_avail,
  input  int_src_t               i_int_src,
  output rbus_t                  o_ring,
  output im_flags_t              o_im_consumed,
  output logic [RING_DATA_W-1:0] o_ctl,
  output logic                   o_int
);

  locl_req_t            locl_req;
  locl_rsp_t            locl_rsp;
  int_ctl_t             int_ctl;
  logic [N_INT_SRC-1:0] int_status;
  logic [N_INT_SRC-1:0] int_enable;

  ring_node #(
    .RING_ADDR_W (RING_ADDR_W),
    .LOCL_ADDR_W (LOCL_ADDR_W)
  ) u_ring (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_ring           (i_ring),
    .i_cfg_start_addr (i_cfg_start_addr),
    .i_cfg_end_addr   (i_cfg_end_addr),
    .i_rsp            (locl_rsp),
    .o_ring           (o_ring),
    .o_req            (locl_req)
  );

  support_regs #(
    .BLKID (BLKID)
  ) u_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_req         (locl_req),
    .i_im_avail    (i_im_avail),
    .i_int_status  (int_status),
    .i_int_enable  (int_enable),
    .o_rsp         (locl_rsp),
    .o_int_ctl     (int_ctl),
    .o_im_consumed (o_im_consumed),
    .o_ctl         (o_ctl)
  );

  event_interrupt #(
    .N_INT_SRC (N_INT_SRC)
  ) u_int (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_int_src (i_int_src),
    .i_int_ctl (int_ctl),
    .o_status  (int_status),
    .o_enable  (int_enable),
    .o_int     (o_int)
  );

endmodule

// File: design/event_interrupt.sv
// Sources are sampled as levels every cycle and the two reserved source bits never set status
`timescale 1ns/1ps

module event_interrupt import support_pkg::*; #(
  parameter int N_INT_SRC = support_pkg::N_INT_SRC
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  int_src_t             i_int_src,
  input  int_ctl_t             i_int_ctl,
  output logic [N_INT_SRC-1:0] o_status,
  output logic [N_INT_SRC-1:0] o_enable,
  output logic                 o_int
);

  int_src_t             src_live;
  logic [N_INT_SRC-1:0] set_bits;
  logic [N_INT_SRC-1:0] clr_bits;
  logic [N_INT_SRC-1:0] status_q;
  logic [N_INT_SRC-1:0] enable_q;

  always_comb begin
    src_live = i_int_src;
    src_live.rsvd = '0;
  end

  assign set_bits = src_live[N_INT_SRC-1:0];
  assign clr_bits = i_int_ctl.wr_status ? i_int_ctl.data[N_INT_SRC-1:0] : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
      enable_q <= '0;
      o_int    <= 1'b0;
    end else begin
      // A source that is high on the clearing edge keeps its bit set
      status_q <= (status_q & ~clr_bits) | set_bits;
      if (i_int_ctl.wr_enable) begin
        enable_q <= i_int_ctl.data[N_INT_SRC-1:0];
      end
      o_int <= |(status_q & enable_q);
    end
  end

  assign o_status = status_q;
  assign o_enable = enable_q;

endmodule

// File: design/support_regs.sv
// Offsets 6 and 7 are unmapped and the revision half of the ID word reads as zero
`timescale 1ns/1ps

module support_regs import support_pkg::*; #(
  parameter logic [15:0] BLKID = DEFAULT_BLKID
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  locl_req_t              i_req,
  input  im_flags_t              i_im_avail,
  input  logic [N_INT_SRC-1:0]   i_int_status,
  input  logic [N_INT_SRC-1:0]   i_int_enable,
  output locl_rsp_t              o_rsp,
  output int_ctl_t               o_int_ctl,
  output im_flags_t              o_im_consumed,
  output logic [RING_DATA_W-1:0] o_ctl
);

  reg_idx_e               reg_idx;
  logic                   is_rd;
  logic                   is_wr;
  logic                   bad_access;
  logic [RING_DATA_W-1:0] rd_data;
  im_flags_t              avail_q;

  assign reg_idx = reg_idx_e'(i_req.idx);
  assign is_rd = (i_req.op == OP_READ);
  assign is_wr = (i_req.op == OP_WRITE);

  // Read mux and access check in the request cycle
  always_comb begin
    rd_data = '0;
    bad_access = 1'b0;
    case (reg_idx)
      REG_BLKID: begin
        rd_data = RING_DATA_W'(BLKID);
        bad_access = is_wr; // Read only
      end
      REG_CTL: begin
        rd_data = o_ctl;
      end
      REG_IM_AVAIL: begin
        rd_data = RING_DATA_W'(avail_q);
        bad_access = is_wr; // Read only
      end
      REG_IM_CONSUMED: begin
        bad_access = is_rd; // Write only
      end
      REG_INT_STATUS: begin
        rd_data = RING_DATA_W'(i_int_status);
      end
      REG_INT_ENABLE: begin
        rd_data = RING_DATA_W'(i_int_enable);
      end
      default: begin
        bad_access = 1'b1;
      end
    endcase
  end

  // The interrupt stage takes its writes on the same edge as this stage
  always_comb begin
    o_int_ctl.wr_status = is_wr && (reg_idx == REG_INT_STATUS);
    o_int_ctl.wr_enable = is_wr && (reg_idx == REG_INT_ENABLE);
    o_int_ctl.data      = i_req.wr_data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rsp         <= '0;
      o_ctl         <= '0;
      o_im_consumed <= '0;
      avail_q       <= '0;
    end else begin
      avail_q <= i_im_avail;
      o_rsp.ack     <= (is_rd || is_wr) && !bad_access;
      o_rsp.err_ack <= (is_rd || is_wr) && bad_access;
      o_rsp.rd_data <= is_rd ? rd_data : '0;
      o_im_consumed <= '0; // Pulses last a single cycle
      if (is_wr && !bad_access) begin
        if (reg_idx == REG_CTL) begin
          o_ctl <= i_req.wr_data;
        end
        if (reg_idx == REG_IM_CONSUMED) begin
          o_im_consumed <= im_flags_t'(i_req.wr_data[$bits(im_flags_t)-1:0]);
        end
      end
    end
  end

endmodule

// File: design/ring_node.sv
// Window bounds are inclusive word addresses and a window wider than eight words aliases offsets
`timescale 1ns/1ps

module ring_node import support_pkg::*; #(
  parameter int RING_ADDR_W = support_pkg::RING_ADDR_W,
  parameter int LOCL_ADDR_W = support_pkg::LOCL_ADDR_W
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  rbus_t                  i_ring,
  input  logic [RING_ADDR_W-1:0] i_cfg_start_addr,
  input  logic [RING_ADDR_W-1:0] i_cfg_end_addr,
  input  locl_rsp_t              i_rsp,
  output rbus_t                  o_ring,
  output locl_req_t              o_req
);

  logic                   is_access;
  logic                   is_hit;
  logic [RING_ADDR_W-1:0] addr_ofs;
  access_op_e             entry_op;
  rbus_t                  s1_ring;
  rbus_t                  s2_ring;
  access_op_e             s1_op;
  access_op_e             s2_op;
  logic [LOCL_ADDR_W-1:0] s1_idx;

  assign is_access = i_ring.rd_strb | i_ring.wr_strb;
  // Words already answered upstream pass by untouched
  assign is_hit = is_access && !i_ring.ack && !i_ring.err_ack &&
                  (i_ring.addr >= i_cfg_start_addr) && (i_ring.addr <= i_cfg_end_addr);
  assign addr_ofs = i_ring.addr - i_cfg_start_addr;

  always_comb begin
    if (!is_hit) begin
      entry_op = OP_NONE;
    end else if (i_ring.wr_strb) begin
      entry_op = OP_WRITE; // A write strobe takes priority over a read strobe
    end else begin
      entry_op = OP_READ;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_ring <= '0;
      s1_op   <= OP_NONE;
      s1_idx  <= '0;
      s2_ring <= '0;
      s2_op   <= OP_NONE;
    end else begin
      s1_ring <= i_ring;
      s1_op   <= entry_op;
      s1_idx  <= addr_ofs[LOCL_ADDR_W-1:0];
      s2_ring <= s1_ring;
      s2_op   <= s1_op;
    end
  end

  always_comb begin
    o_req.op      = s1_op;
    o_req.idx     = s1_idx;
    o_req.wr_data = s1_ring.wr_data;
  end

  // The register stage answers in the same cycle the word leaves the node
  always_comb begin
    o_ring = s2_ring;
    if (s2_op != OP_NONE) begin
      o_ring.ack     = i_rsp.ack;
      o_ring.err_ack = i_rsp.err_ack;
      if (s2_op == OP_READ) begin
        o_ring.rd_data = i_rsp.rd_data;
      end
    end
  end

endmodule

// File: design/support_pkg.sv
// Ring and register widths are fixed here and the node window maps at most eight registers
package support_pkg;

  localparam int RING_ADDR_W = 16;
  localparam int RING_DATA_W = 32;
  localparam int LOCL_ADDR_W = 3;
  localparam int N_INT_SRC = 16;
  localparam logic [15:0] DEFAULT_BLKID = 16'hcd51;

  typedef struct packed {
    logic [RING_ADDR_W-1:0] addr;
    logic                   wr_strb;
    logic [RING_DATA_W-1:0] wr_data;
    logic                   rd_strb;
    logic [RING_DATA_W-1:0] rd_data;
    logic                   ack;
    logic                   err_ack;
  } rbus_t;

  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } access_op_e;

  typedef struct packed {
    access_op_e             op;
    logic [LOCL_ADDR_W-1:0] idx;
    logic [RING_DATA_W-1:0] wr_data;
  } locl_req_t;

  typedef struct packed {
    logic                   ack;
    logic                   err_ack;
    logic [RING_DATA_W-1:0] rd_data;
  } locl_rsp_t;

  typedef enum logic [LOCL_ADDR_W-1:0] {
    REG_BLKID       = 3'd0,
    REG_CTL         = 3'd1,
    REG_IM_AVAIL    = 3'd2,
    REG_IM_CONSUMED = 3'd3,
    REG_INT_STATUS  = 3'd4,
    REG_INT_ENABLE  = 3'd5
  } reg_idx_e;

  typedef struct packed {
    logic bank_hi;
    logic bank_lo;
  } im_bank_t;

  // The htf_bl engine sits in the low two bits
  typedef struct packed {
    im_bank_t xpd;
    im_bank_t lz77d;
    im_bank_t htf_bl;
  } im_flags_t;

  typedef struct packed {
    logic [1:0] rsvd;
    logic       xp10_uncor_ecc;
    logic       xp10_tlvp;
    logic       su_uncor_ecc;
    logic       cg_tlvp;
    logic       crcc0_tlvp;
    logic       crcg0_tlvp;
    logic       prefix_tlvp;
    logic       osf_tlvp;
    logic       osf_uncor_ecc;
    logic       isf_sys_stall;
    logic       isf_ovfl;
    logic       isf_prot_err;
    logic       isf_tlvp;
    logic       isf_uncor_ecc;
  } int_src_t;

  typedef struct packed {
    logic                   wr_status;
    logic                   wr_enable;
    logic [RING_DATA_W-1:0] data;
  } int_ctl_t;

endpackage
